/* files.f */
design/mem_pkg.sv
design/dbus_if.sv
design/store_align.sv
design/resp_collect.sv
design/load_align.sv
design/mem_stage.sv
bench/dbus_model.sv
bench/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module mem_stage_tb -f files.f || exit 1
out=$(./obj_dir/Vmem_stage_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* bench/mem_stage_tb.sv */
`timescale 1ns/100ps

module mem_stage_tb import mem_pkg::*; ();

    localparam int    NUM_PAIRS = 300;
    localparam int    TIMEOUT   = NUM_PAIRS * 20;
    localparam addr_t BASE      = 32'h0000_2000;

    logic                    clk;
    logic                    resetn;
    logic                    issue;
    mem_op_t [NUM_LANES-1:0] lane_op;
    msize_t  [NUM_LANES-1:0] lane_size;
    logic    [NUM_LANES-1:0] lane_sext;
    addr_t   [NUM_LANES-1:0] lane_addr;
    word_t   [NUM_LANES-1:0] lane_wdata;
    logic                    busy;
    logic                    done;
    word_t   [NUM_LANES-1:0] lane_rdata;
    logic    [NUM_LANES-1:0] d_valid;
    logic    [NUM_LANES-1:0] d_write;
    logic    [NUM_LANES-1:0] d_addr_ok;
    logic    [NUM_LANES-1:0] d_data_ok;
    addr_t   [NUM_LANES-1:0] d_addr;
    strobe_t [NUM_LANES-1:0] d_strobe;
    word_t   [NUM_LANES-1:0] d_wdata;
    word_t   [NUM_LANES-1:0] d_rdata;

    // shadow of the bus memory and what the current pair should return
    word_t                   shadow [16];
    logic    [NUM_LANES-1:0] exp_load;
    word_t   [NUM_LANES-1:0] exp_rdata;

    // pair tracking in the checker
    int                      cycle;
    int                      done_count;
    int                      issue_cycle;
    int                      ok_cycle [NUM_LANES];
    logic                    in_flight;
    mem_op_t [NUM_LANES-1:0] flight_op;
    addr_t   [NUM_LANES-1:0] flight_addr;
    logic    [NUM_LANES-1:0] held;
    logic    [NUM_LANES-1:0] prev_write;
    addr_t   [NUM_LANES-1:0] prev_addr;
    strobe_t [NUM_LANES-1:0] prev_strobe;
    word_t   [NUM_LANES-1:0] prev_wdata;

    mem_stage i_mem_stage (.*);

    dbus_model i_dbus_model (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (d_valid),
        .write   (d_write),
        .addr    (d_addr),
        .strobe  (d_strobe),
        .wdata   (d_wdata),
        .addr_ok (d_addr_ok),
        .data_ok (d_data_ok),
        .rdata   (d_rdata)
    );

    // expected load result from the memory word before alignment
    function automatic word_t expected_load(word_t w, logic [1:0] off, msize_t size,
                                            logic sext);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (size)
            SIZE_BYTE: return sext ? {{24{b[7]}}, b} : {24'h0, b};
            SIZE_HALF: return sext ? {{16{h[15]}}, h} : {16'h0, h};
            default:   return w;
        endcase
    endfunction

    task automatic merge_store(int idx, logic [1:0] off, msize_t size, word_t data);
        case (size)
            SIZE_BYTE: shadow[idx][8*off +: 8]  = data[7:0];
            SIZE_HALF: shadow[idx][8*off +: 16] = data[15:0];
            default:   shadow[idx] = data;
        endcase
    endtask

    task automatic abort_run(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        int         idx [NUM_LANES];
        logic [1:0] off;
        void'($urandom(32'ha7e866a4));
        resetn     = 1'b1;
        issue      = 1'b0;
        lane_op[0] = MEM_NONE;
        lane_op[1] = MEM_NONE;
        lane_size  = '0;
        lane_sext  = '0;
        lane_addr  = '0;
        lane_wdata = '0;
        repeat (10) @(negedge clk);
        resetn = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = i_dbus_model.mem[i];
        end
        @(negedge clk);
        assert (!busy && !done && d_valid == '0 && lane_rdata == '0)
            else abort_run("outputs not idle after reset");

        for (int p = 0; p < NUM_PAIRS; p++) begin
            while (busy) @(negedge clk);
            // two different words of the region
            idx[0] = $urandom_range(0, 15);
            idx[1] = (idx[0] + int'($urandom_range(1, 15))) % 16;
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_op[l]    = mem_op_t'(2'($urandom_range(0, 2)));
                lane_size[l]  = 2'($urandom_range(0, 2));
                lane_sext[l]  = 1'($urandom_range(0, 1));
                lane_wdata[l] = $urandom;
                off = 2'($urandom_range(0, 3));
                if (lane_size[l] == SIZE_HALF) off[0] = 1'b0;
                if (lane_size[l] == SIZE_WORD) off = 2'b00;
                lane_addr[l] = BASE + addr_t'(4 * idx[l]) + addr_t'(off);
                exp_load[l]  = (lane_op[l] == MEM_LOAD);
                exp_rdata[l] = expected_load(shadow[idx[l]], off, lane_size[l], lane_sext[l]);
                if (lane_op[l] == MEM_STORE) merge_store(idx[l], off, lane_size[l], lane_wdata[l]);
            end
            issue = 1'b1;
            @(negedge clk);
            // stray pulse while busy would corrupt memory if taken
            issue      = ($urandom_range(0, 3) == 0);
            lane_op[0] = MEM_STORE;
            lane_op[1] = MEM_STORE;
            lane_wdata = {$urandom, $urandom};
            @(negedge clk);
            issue = 1'b0;
            while (done_count != p + 1) @(negedge clk);
        end
        while (busy) @(negedge clk);
        repeat (4) @(negedge clk);
        // bus memory against the shadow after the last pair
        for (int i = 0; i < 16; i++) begin
            assert (i_dbus_model.mem[i] == shadow[i])
                else abort_run($sformatf("word %0d holds %h, expected %h",
                                         i, i_dbus_model.mem[i], shadow[i]));
        end
        $display("No errors");
        $finish;
    end

    // comparing process sampled on the rising edge
    always @(posedge clk) begin
        int exp_cycle;
        if (!resetn) begin
            cycle++;
            if (cycle > TIMEOUT) abort_run("timeout, pairs did not complete in time");
            // busy from the cycle after issue through the done cycle
            assert (busy == in_flight)
                else abort_run($sformatf("busy is %b, expected %b", busy, in_flight));
            for (int l = 0; l < NUM_LANES; l++) begin
                if (held[l]) begin
                    assert (d_valid[l] && d_write[l] == prev_write[l] && d_addr[l] == prev_addr[l]
                            && d_strobe[l] == prev_strobe[l] && d_wdata[l] == prev_wdata[l])
                        else abort_run($sformatf("port %0d request changed before addr_ok", l));
                end
                if (d_valid[l]) begin
                    assert (in_flight && flight_op[l] != MEM_NONE && d_addr[l] == flight_addr[l]
                            && d_write[l] == (flight_op[l] == MEM_STORE))
                        else abort_run($sformatf("port %0d unexpected request %h", l, d_addr[l]));
                end
                if (d_data_ok[l]) ok_cycle[l] = cycle;
            end
            held        = d_valid & ~d_addr_ok;
            prev_write  = d_write;
            prev_addr   = d_addr;
            prev_strobe = d_strobe;
            prev_wdata  = d_wdata;

            if (done) begin
                assert (in_flight) else abort_run("done without a pair in flight");
                exp_cycle = issue_cycle + 1;
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (flight_op[l] != MEM_NONE) begin
                        assert (ok_cycle[l] > issue_cycle)
                            else abort_run($sformatf("done before data_ok on port %0d", l));
                        if (ok_cycle[l] + 1 > exp_cycle) exp_cycle = ok_cycle[l] + 1;
                    end
                    if (exp_load[l]) begin
                        assert (lane_rdata[l] == exp_rdata[l])
                            else abort_run($sformatf("lane %0d load got %h, expected %h",
                                                     l, lane_rdata[l], exp_rdata[l]));
                    end
                end
                assert (cycle == exp_cycle)
                    else abort_run($sformatf("done at cycle %0d, expected %0d", cycle, exp_cycle));
                in_flight = 1'b0;
                done_count++;
            end
            if (issue && !busy) begin
                in_flight   = 1'b1;
                issue_cycle = cycle;
                flight_op   = lane_op;
                flight_addr = lane_addr;
                ok_cycle    = '{0, 0};
            end
        end
    end

    initial begin
        cycle      = 0;
        done_count = 0;
        in_flight  = 1'b0;
        held       = '0;
    end

endmodule

/* bench/dbus_model.sv */
`timescale 1ns/100ps

module dbus_model import mem_pkg::*; (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic    [NUM_LANES-1:0] valid,
    input  logic    [NUM_LANES-1:0] write,
    input  addr_t   [NUM_LANES-1:0] addr,
    input  strobe_t [NUM_LANES-1:0] strobe,
    input  word_t   [NUM_LANES-1:0] wdata,
    output logic    [NUM_LANES-1:0] addr_ok,
    output logic    [NUM_LANES-1:0] data_ok,
    output word_t   [NUM_LANES-1:0] rdata
);

    localparam addr_t BASE = 32'h0000_2000;

    word_t                mem [16];
    word_t                reply [NUM_LANES];
    logic [NUM_LANES-1:0] pending;
    int                   grant_wait [NUM_LANES];
    int                   reply_wait [NUM_LANES];

    // contents tied to the full byte address of each word
    initial begin
        addr_t a;
        addr_ok = '0;
        data_ok = '0;
        rdata   = '0;
        pending = '0;
        for (int i = 0; i < 16; i++) begin
            a      = BASE + addr_t'(4 * i);
            mem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h6b2f_91c4;
        end
    end

    // acceptance on the rising edge, writes land under the strobe
    always @(posedge clk) begin
        for (int p = 0; p < NUM_LANES; p++) begin
            if (!resetn && valid[p] && addr_ok[p]) begin
                if (write[p]) begin
                    for (int b = 0; b < 4; b++) begin
                        if (strobe[p][b]) begin
                            mem[addr[p][5:2]][8*b +: 8] = wdata[p][8*b +: 8];
                        end
                    end
                end
                reply[p]      = mem[addr[p][5:2]];
                pending[p]    = 1'b1;
                grant_wait[p] = $urandom_range(0, 3);
                reply_wait[p] = $urandom_range(0, 4);
            end
        end
    end

    // response side only moves on the falling edge
    always @(negedge clk) begin
        for (int p = 0; p < NUM_LANES; p++) begin
            data_ok[p] = 1'b0;
            // noise outside data_ok
            rdata[p]   = $urandom;
            if (resetn) begin
                addr_ok[p]    = 1'b0;
                pending[p]    = 1'b0;
                grant_wait[p] = $urandom_range(0, 3);
            end else begin
                addr_ok[p] = valid[p] && (grant_wait[p] == 0);
                if (valid[p] && grant_wait[p] > 0) begin
                    grant_wait[p]--;
                end
                if (pending[p]) begin
                    if (reply_wait[p] == 0) begin
                        data_ok[p] = 1'b1;
                        rdata[p]   = reply[p];
                        pending[p] = 1'b0;
                    end else begin
                        reply_wait[p]--;
                    end
                end
            end
        end
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      issue,

    input  mem_op_t [NUM_LANES-1:0]   lane_op,
    input  msize_t  [NUM_LANES-1:0]   lane_size,
    input  logic    [NUM_LANES-1:0]   lane_sext,
    input  addr_t   [NUM_LANES-1:0]   lane_addr,
    input  word_t   [NUM_LANES-1:0]   lane_wdata,

    output logic                      busy,
    output logic                      done,
    output word_t   [NUM_LANES-1:0]   lane_rdata,

    output logic    [NUM_LANES-1:0]   d_valid,
    output logic    [NUM_LANES-1:0]   d_write,
    output addr_t   [NUM_LANES-1:0]   d_addr,
    output strobe_t [NUM_LANES-1:0]   d_strobe,
    output word_t   [NUM_LANES-1:0]   d_wdata,
    input  logic    [NUM_LANES-1:0]   d_addr_ok,
    input  logic    [NUM_LANES-1:0]   d_data_ok,
    input  word_t   [NUM_LANES-1:0]   d_rdata
);

    logic  issue_go;
    word_t [NUM_LANES-1:0] saved;
    word_t [NUM_LANES-1:0] aligned;
    word_t [NUM_LANES-1:0] rdata_hold;

    dbus_if bus [NUM_LANES] ();

    // one pair in flight, a pulse while busy is dropped
    assign issue_go = issue && !busy;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane

        msize_t     size_q;
        logic       sext_q;
        logic [1:0] addr_low_q;

        // plain port mapping for this bus port
        assign d_valid[i]  = bus[i].valid;
        assign d_write[i]  = bus[i].write;
        assign d_addr[i]   = bus[i].addr;
        assign d_strobe[i] = bus[i].strobe;
        assign d_wdata[i]  = bus[i].wdata;

        assign bus[i].addr_ok = d_addr_ok[i];
        assign bus[i].data_ok = d_data_ok[i];
        assign bus[i].rdata   = d_rdata[i];

        store_align i_store_align (
            .clk    (clk),
            .resetn (resetn),
            .issue  (issue_go),
            .op     (lane_op[i]),
            .size   (lane_size[i]),
            .addr   (lane_addr[i]),
            .wdata  (lane_wdata[i]),
            .bus    (bus[i])
        );

        // load shape kept for the alignment after the reply
        always_ff @(posedge clk) begin
            if (issue_go) begin
                size_q     <= lane_size[i];
                sext_q     <= lane_sext[i];
                addr_low_q <= lane_addr[i][1:0];
            end
        end

        load_align i_load_align (
            .raw      (saved[i]),
            .addr_low (addr_low_q),
            .size     (size_q),
            .sext     (sext_q),
            .rd       (aligned[i])
        );

        // result held from done to the next done
        always_ff @(posedge clk) begin
            if (resetn) begin
                rdata_hold[i] <= '0;
            end else if (done) begin
                rdata_hold[i] <= aligned[i];
            end
        end

        assign lane_rdata[i] = done ? aligned[i] : rdata_hold[i];

    end

    resp_collect i_resp_collect (
        .clk    (clk),
        .resetn (resetn),
        .issue  (issue_go),
        .op     (lane_op),
        .bus0   (bus[0]),
        .bus1   (bus[1]),
        .saved  (saved),
        .busy   (busy),
        .done   (done)
    );

endmodule

/* design/load_align.sv */
`timescale 1ns/100ps

module load_align import mem_pkg::*; (
    input  word_t      raw,
    input  logic [1:0] addr_low,
    input  msize_t     size,
    input  logic       sext,
    output word_t      rd
);

    word_t shifted;
    logic  fill_byte;
    logic  fill_half;

    // addressed byte or halfword brought down to bit 0
    assign shifted = raw >> {addr_low, 3'b000};

    // extension bit, zero for unsigned loads
    assign fill_byte = sext && shifted[7];
    assign fill_half = sext && shifted[15];

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                rd = {{24{fill_byte}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                rd = {{16{fill_half}}, shifted[15:0]};
            end
            SIZE_WORD: begin
                rd = raw;
            end
            default: begin
                rd = raw;
            end
        endcase
    end

endmodule

/* design/resp_collect.sv */
`timescale 1ns/100ps

module resp_collect import mem_pkg::*; (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         issue,
    input  mem_op_t [NUM_LANES-1:0]      op,
    dbus_if.resp                         bus0,
    dbus_if.resp                         bus1,
    output word_t   [NUM_LANES-1:0]      saved,
    output logic                         busy,
    output logic                         done
);

    lane_state_t [NUM_LANES-1:0] state;
    logic        [NUM_LANES-1:0] accepted;

    logic        [NUM_LANES-1:0] req_valid;
    logic        [NUM_LANES-1:0] addr_ok;
    logic        [NUM_LANES-1:0] data_ok;
    word_t       [NUM_LANES-1:0] rdata;
    logic                        all_done;

    // gather both ports so the lanes share one description
    assign req_valid = {bus1.valid, bus0.valid};
    assign addr_ok   = {bus1.addr_ok, bus0.addr_ok};
    assign data_ok   = {bus1.data_ok, bus0.data_ok};
    assign rdata     = {bus1.rdata, bus0.rdata};

    // order free, whichever lane finishes last closes the pair
    assign all_done = (state[0] == LANE_DONE) && (state[1] == LANE_DONE);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane

        always_ff @(posedge clk) begin
            if (resetn) begin
                state[i]    <= LANE_IDLE;
                accepted[i] <= 1'b0;
            end else begin
                // request taken by the bus, reply still owed
                if (req_valid[i] && addr_ok[i]) begin
                    accepted[i] <= 1'b1;
                end else if (data_ok[i]) begin
                    accepted[i] <= 1'b0;
                end

                case (state[i])
                    LANE_IDLE: begin
                        if (issue) begin
                            state[i] <= (op[i] == MEM_NONE) ? LANE_DONE : LANE_WAIT;
                        end
                    end
                    LANE_WAIT: begin
                        if (accepted[i] && data_ok[i]) begin
                            state[i] <= LANE_DONE;
                        end
                    end
                    LANE_DONE: begin
                        // early lane parks here until its partner is through
                        if (all_done) begin
                            state[i] <= LANE_IDLE;
                        end
                    end
                    default: begin
                        state[i] <= LANE_IDLE;
                    end
                endcase
            end
        end

        // reply word kept until the pair completes
        always_ff @(posedge clk) begin
            if ((state[i] == LANE_WAIT) && accepted[i] && data_ok[i]) begin
                saved[i] <= rdata[i];
            end
        end

    end

    assign busy = (state[0] != LANE_IDLE) || (state[1] != LANE_IDLE);
    assign done = all_done;

endmodule

/* design/store_align.sv */
`timescale 1ns/100ps

module store_align import mem_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    issue,
    input  mem_op_t op,
    input  msize_t  size,
    input  addr_t   addr,
    input  word_t   wdata,
    dbus_if.req     bus
);

    logic    valid_q;
    logic    write_q;
    addr_t   addr_q;
    strobe_t strobe_q;
    word_t   wdata_q;

    strobe_t strobe_d;
    word_t   wdata_d;

    // byte enables and lane placement of the store data
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                strobe_d = 4'b0001 << addr[1:0];
                wdata_d  = {4{wdata[7:0]}};
            end
            SIZE_HALF: begin
                strobe_d = 4'b0011 << addr[1:0];
                wdata_d  = {2{wdata[15:0]}};
            end
            SIZE_WORD: begin
                strobe_d = 4'b1111;
                wdata_d  = wdata;
            end
            default: begin
                strobe_d = 4'b0000;
                wdata_d  = wdata;
            end
        endcase
        // loads write nothing
        if (op != MEM_STORE) begin
            strobe_d = 4'b0000;
        end
    end

    // request valid, raised the cycle after issue, dropped after acceptance
    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= 1'b0;
        end else if (issue) begin
            valid_q <= (op != MEM_NONE);
        end else if (valid_q && bus.addr_ok) begin
            valid_q <= 1'b0;
        end
    end

    // request payload, steady while waiting for addr_ok
    always_ff @(posedge clk) begin
        if (issue) begin
            write_q  <= (op == MEM_STORE);
            addr_q   <= addr;
            strobe_q <= strobe_d;
            wdata_q  <= wdata_d;
        end
    end

    assign bus.valid  = valid_q;
    assign bus.write  = write_q;
    assign bus.addr   = addr_q;
    assign bus.strobe = strobe_q;
    assign bus.wdata  = wdata_q;

endmodule

/* design/dbus_if.sv */
`timescale 1ns/100ps

interface dbus_if import mem_pkg::*; ();

    // request side
    logic    valid;
    logic    write;
    addr_t   addr;
    strobe_t strobe;
    word_t   wdata;

    // response side
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;

    // request fields are held until valid and addr_ok meet
    modport req (
        output valid,
        output write,
        output addr,
        output strobe,
        output wdata,
        input  addr_ok
    );

    modport resp (
        input valid,
        input addr_ok,
        input data_ok,
        input rdata
    );

endinterface

/* design/mem_pkg.sv */
package mem_pkg;

    // two issue lanes, lane 0 is the older instruction
    localparam int NUM_LANES = 2;

    // one data word and one byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // byte enables, bit n covers byte n of the word
    typedef logic [3:0] strobe_t;

    // access size code
    typedef logic [1:0] msize_t;

    localparam msize_t SIZE_BYTE = 2'd0;
    localparam msize_t SIZE_HALF = 2'd1;
    localparam msize_t SIZE_WORD = 2'd2;

    // memory operation carried by one lane
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    // per-lane completion tracking in the collector
    typedef enum logic [1:0] {
        LANE_IDLE = 2'd0,
        LANE_WAIT = 2'd1,
        LANE_DONE = 2'd2
    } lane_state_t;

endpackage
